// File: include/sj_video_consts.svh
/* SJ video back end constants
   CPU address map, bus and palette widths, register reset values */

`ifndef SJ_VIDEO_CONSTS_SVH
`define SJ_VIDEO_CONSTS_SVH

// ====================
// Bus widths
`define SJ_ADDR_W       16
`define SJ_DATA_W       8

// ====================
// Palette geometry
`define SJ_PAL_ENTRIES  64
`define SJ_PAL_IDX_W    6
`define SJ_PAL_W        9      // Ninth bit comes from the latch
`define SJ_RGB_W        3

// ====================
// CPU write map
`define SJ_A_COLOR12    16'hD506   // Tilemap 1 and 2 colour codes
`define SJ_A_COLOR3     16'hD507   // Tilemap 3 and sprite colour codes
`define SJ_A_COINSET    16'hD50E   // Bank select, sound stop, coin lock
`define SJ_PRY_PAGE     8'hD3      // Whole page decodes to priority
`define SJ_PAL_PAGE     8'hD2      // Whole page decodes to palette

// CPU read map
`define SJ_A_IN0        16'hD408
`define SJ_A_IN1        16'hD409
`define SJ_A_DIPA       16'hD40A
`define SJ_IN0_HI       2'b10      // Fixed upper bits of IN0
`define SJ_IN1_VAL      8'hFF

// ====================
// Reset values
`define SJ_PRY_W        8
`define SJ_PRY_RST      8'h00

`endif

// File: design/sj_video_pkg.sv
/* SJ video shared types
   CPU bus, decoded write strokes, pixel and palette request structs */

`default_nettype none

`include "sj_video_consts.svh"

package sj_video_pkg;

	// ====================
	// CPU side
	typedef struct packed {
		logic [`SJ_ADDR_W-1:0] addr;
		logic [`SJ_DATA_W-1:0] wdata;
		logic                  wr;    // One-cycle write strobe
		logic                  rd;    // Read strobe, data same cycle
	} cpu_bus_t;

	typedef enum logic [2:0] {
		TGT_NONE,
		TGT_COLOR12,
		TGT_COLOR3,
		TGT_PRIORITY,
		TGT_COINSET,
		TGT_PALETTE
	} reg_target_e;

	typedef struct packed {
		reg_target_e           target;
		logic [6:0]            pal_addr;   // Bit 0 picks latch or entry
		logic [`SJ_DATA_W-1:0] data;
	} reg_write_t;

	typedef struct packed {
		logic left;
		logic right;
		logic down;
		logic up;
		logic shoot;
		logic shoot2;
	} player_in_t;

	// ====================
	// Pixel side
	typedef enum logic [1:0] {
		LAYER_OBJ,
		LAYER_TM1,
		LAYER_TM2,
		LAYER_TM3
	} layer_e;

	typedef struct packed {
		logic [1:0] md0;   // Sprite code
		logic [2:0] md1;
		logic [2:0] md2;
		logic [2:0] md3;
	} color_codes_t;

	typedef struct packed {
		logic [3:0] obj;
		logic [2:0] tm1;
		logic [2:0] tm2;
		logic [2:0] tm3;
		logic       blank;
	} layer_pix_t;

	typedef struct packed {
		logic [`SJ_PAL_IDX_W-1:0] idx;
		logic                     blank;
	} pal_req_t;

endpackage

`default_nettype wire

// File: design/cpu_port_decode.sv
/* CPU port decode
   Turns bus writes into register strokes and selects CPU read data */

`timescale 1ns/1ns
`default_nettype none

`include "sj_video_consts.svh"

module cpu_port_decode (
	input  sj_video_pkg::cpu_bus_t      cpu_i,
	input  sj_video_pkg::player_in_t    players_i,
	input  logic [`SJ_DATA_W-1:0]       dip1_i,
	output sj_video_pkg::reg_write_t    wr_o,
	output logic [`SJ_DATA_W-1:0]       rdata_o
);

	import sj_video_pkg::*;

	reg_target_e target;
	logic [7:0]  page;

	assign page = cpu_i.addr[15:8];

	// ====================
	// Write decode
	always_comb begin
		target = TGT_NONE;
		if (cpu_i.wr) begin
			if (cpu_i.addr == `SJ_A_COLOR12) begin
				target = TGT_COLOR12;
			end else if (cpu_i.addr == `SJ_A_COLOR3) begin
				target = TGT_COLOR3;
			end else if (cpu_i.addr == `SJ_A_COINSET) begin
				target = TGT_COINSET;
			end else if (page == `SJ_PRY_PAGE) begin
				target = TGT_PRIORITY;   // D300-D3FF
			end else if (page == `SJ_PAL_PAGE) begin
				target = TGT_PALETTE;    // D200-D2FF
			end
		end
	end

	always_comb begin
		wr_o.target   = target;
		wr_o.pal_addr = cpu_i.addr[6:0];   // Bit 7 dropped here
		wr_o.data     = cpu_i.wdata;
	end

	// ====================
	// Read mux
	always_comb begin
		rdata_o = '0;
		if (cpu_i.rd) begin
			case (cpu_i.addr)
				`SJ_A_IN0: begin
					rdata_o = {`SJ_IN0_HI, players_i.shoot2, players_i.shoot,
						players_i.up, players_i.down, players_i.right, players_i.left};
				end
				`SJ_A_IN1: begin
					rdata_o = `SJ_IN1_VAL;   // No inputs wired here
				end
				`SJ_A_DIPA: begin
					rdata_o = ~dip1_i;       // Switches read active low
				end
				default: begin
					rdata_o = '0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/video_ctrl_regs.sv
/* Video control registers
   Colour codes, layer priority and the coin-set bits, loaded by CPU strokes */

`timescale 1ns/1ns
`default_nettype none

`include "sj_video_consts.svh"

module video_ctrl_regs (
	input  logic                         V_BLANK,
	input  logic                         EXROM2,
	input  sj_video_pkg::reg_write_t     wr_i,
	output sj_video_pkg::color_codes_t   codes_o,
	output logic [`SJ_PRY_W-1:0]         priority_o,
	output logic                         bank_sel_o,
	output logic                         sound_stop_o,
	output logic                         coin_lock_o
);

	import sj_video_pkg::*;

	color_codes_t          codes_q;
	logic [`SJ_PRY_W-1:0]  pry_q;

	// ====================
	// Colour codes
	always_ff @(posedge V_BLANK or negedge EXROM2) begin
		if (!EXROM2) begin
			codes_q <= '0;
		end else begin
			case (wr_i.target)
				TGT_COLOR12: begin
					codes_q.md1 <= wr_i.data[2:0];
					codes_q.md2 <= wr_i.data[6:4];   // Bank bits 3 and 7 unused
				end
				TGT_COLOR3: begin
					codes_q.md3 <= wr_i.data[2:0];
					codes_q.md0 <= wr_i.data[5:4];
				end
				default: begin
				end
			endcase
		end
	end

	// ====================
	// Priority slots
	always_ff @(posedge V_BLANK or negedge EXROM2) begin
		if (!EXROM2) begin
			pry_q <= `SJ_PRY_RST;
		end else if (wr_i.target == TGT_PRIORITY) begin
			pry_q <= wr_i.data;   // Four 2-bit slots, slot 0 in front
		end
	end

	// ====================
	// Coin set
	always_ff @(posedge V_BLANK or negedge EXROM2) begin
		if (!EXROM2) begin
			bank_sel_o   <= 1'b0;
			sound_stop_o <= 1'b0;
			coin_lock_o  <= 1'b0;
		end else if (wr_i.target == TGT_COINSET) begin
			bank_sel_o   <= wr_i.data[7];   // ROM bank select
			sound_stop_o <= wr_i.data[1];
			coin_lock_o  <= wr_i.data[0];
		end
	end

	assign codes_o    = codes_q;
	assign priority_o = pry_q;

endmodule

`default_nettype wire

// File: design/layer_priority_mixer.sv
/* Layer priority mixer
   Picks the front opaque layer by priority slot and forms the palette index */

`timescale 1ns/1ns
`default_nettype none

`include "sj_video_consts.svh"

module layer_priority_mixer (
	input  logic                         V_BLANK,
	input  logic                         EXROM2,
	input  sj_video_pkg::layer_pix_t     pix_i,
	input  sj_video_pkg::color_codes_t   codes_i,
	input  logic [`SJ_PRY_W-1:0]         priority_i,
	output sj_video_pkg::pal_req_t       req_o
);

	import sj_video_pkg::*;

	logic [3:0]               opaque;   // Indexed by layer_e value
	layer_e                   slot_layer [4];
	layer_e                   sel;
	logic [`SJ_PAL_IDX_W-1:0] idx;

	// ====================
	// Opacity and slots
	always_comb begin
		opaque[LAYER_OBJ] = |pix_i.obj;
		opaque[LAYER_TM1] = |pix_i.tm1;
		opaque[LAYER_TM2] = |pix_i.tm2;
		opaque[LAYER_TM3] = |pix_i.tm3;
	end

	always_comb begin
		for (int k = 0; k < 4; k++) begin
			slot_layer[k] = layer_e'(priority_i[2*k +: 2]);
		end
	end

	// Walk from the back slot toward the front, so the
	// frontmost opaque slot wins. Slot 3 stays if none is opaque.
	always_comb begin
		sel = slot_layer[3];
		for (int k = 2; k >= 0; k--) begin
			if (opaque[slot_layer[k]]) begin
				sel = slot_layer[k];
			end
		end
	end

	// ====================
	// Palette index
	always_comb begin
		case (sel)
			LAYER_OBJ: idx = {codes_i.md0, pix_i.obj};   // 2 + 4 bits
			LAYER_TM1: idx = {codes_i.md1, pix_i.tm1};
			LAYER_TM2: idx = {codes_i.md2, pix_i.tm2};
			LAYER_TM3: idx = {codes_i.md3, pix_i.tm3};
			default:   idx = '0;
		endcase
	end

	always_ff @(posedge V_BLANK or negedge EXROM2) begin
		if (!EXROM2) begin
			req_o.idx   <= '0;
			req_o.blank <= 1'b1;   // Dark until real pixels arrive
		end else begin
			req_o.idx   <= idx;
			req_o.blank <= pix_i.blank;
		end
	end

endmodule

`default_nettype wire

// File: design/palette_ram.sv
/* Palette RAM
   64 x 9 colour store with ninth-bit latch, inverted RGB out and blanking */

`timescale 1ns/1ns
`default_nettype none

`include "sj_video_consts.svh"

module palette_ram (
	input  logic                       V_BLANK,
	input  logic                       EXROM2,
	input  sj_video_pkg::reg_write_t   wr_i,
	input  sj_video_pkg::pal_req_t     req_i,
	output logic [`SJ_RGB_W-1:0]       red_o,
	output logic [`SJ_RGB_W-1:0]       green_o,
	output logic [`SJ_RGB_W-1:0]       blue_o
);

	import sj_video_pkg::*;

	logic [`SJ_PAL_W-1:0]     mem [`SJ_PAL_ENTRIES];
	logic                     bit8_q;
	logic                     pal_wr;
	logic [`SJ_PAL_IDX_W-1:0] wr_idx;
	logic [`SJ_PAL_W-1:0]     rd_q;
	logic                     rd_blank_q;

	assign pal_wr = (wr_i.target == TGT_PALETTE);
	assign wr_idx = wr_i.pal_addr[6:1];

	// ====================
	// CPU write side
	always_ff @(posedge V_BLANK or negedge EXROM2) begin
		if (!EXROM2) begin
			bit8_q <= 1'b0;
		end else if (pal_wr && wr_i.pal_addr[0]) begin
			bit8_q <= wr_i.data[0];   // Odd address loads ninth bit
		end
	end

	// Even address commits latch plus data byte, pixel read is registered
	always_ff @(posedge V_BLANK) begin
		if (pal_wr && !wr_i.pal_addr[0]) begin
			mem[wr_idx] <= {bit8_q, wr_i.data};
		end
		rd_q <= mem[req_i.idx];
	end

	// ====================
	// Pixel side
	always_ff @(posedge V_BLANK or negedge EXROM2) begin
		if (!EXROM2) begin
			rd_blank_q <= 1'b1;
		end else begin
			rd_blank_q <= req_i.blank;   // Follows rd_q
		end
	end

	always_ff @(posedge V_BLANK or negedge EXROM2) begin
		if (!EXROM2) begin
			red_o   <= '0;
			green_o <= '0;
			blue_o  <= '0;
		end else if (rd_blank_q) begin
			red_o   <= '0;
			green_o <= '0;
			blue_o  <= '0;
		end else begin
			red_o   <= ~rd_q[8:6];   // Entry stored active low
			green_o <= ~rd_q[5:3];
			blue_o  <= ~rd_q[2:0];
		end
	end

endmodule

`default_nettype wire

// File: design/sj_video_top.sv
/* SJ video back end top
   CPU decode, control registers, priority mixer and palette output */

`timescale 1ns/1ns
`default_nettype none

`include "sj_video_consts.svh"

module sj_video_top (
	input  logic                        V_BLANK,
	input  logic                        EXROM2,
	input  sj_video_pkg::cpu_bus_t      cpu_i,
	input  sj_video_pkg::layer_pix_t    pix_i,
	input  sj_video_pkg::player_in_t    players_i,
	input  logic [`SJ_DATA_W-1:0]       dip1_i,
	output logic [`SJ_DATA_W-1:0]       rdata_o,
	output logic [`SJ_RGB_W-1:0]        red_o,
	output logic [`SJ_RGB_W-1:0]        green_o,
	output logic [`SJ_RGB_W-1:0]        blue_o,
	output logic                        bank_sel_o,
	output logic                        sound_stop_o,
	output logic                        coin_lock_o
);

	import sj_video_pkg::*;

	reg_write_t            wr;
	color_codes_t          codes;
	logic [`SJ_PRY_W-1:0]  pry;
	pal_req_t              req;

	// ====================
	// CPU side
	cpu_port_decode cpu_port_decode_i (
		.cpu_i     (cpu_i),
		.players_i (players_i),
		.dip1_i    (dip1_i),
		.wr_o      (wr),
		.rdata_o   (rdata_o)
	);

	video_ctrl_regs video_ctrl_regs_i (
		.V_BLANK      (V_BLANK),
		.EXROM2       (EXROM2),
		.wr_i         (wr),
		.codes_o      (codes),
		.priority_o   (pry),
		.bank_sel_o   (bank_sel_o),
		.sound_stop_o (sound_stop_o),
		.coin_lock_o  (coin_lock_o)
	);

	// ====================
	// Pixel path, 3 cycles
	layer_priority_mixer layer_priority_mixer_i (
		.V_BLANK    (V_BLANK),
		.EXROM2     (EXROM2),
		.pix_i      (pix_i),
		.codes_i    (codes),
		.priority_i (pry),
		.req_o      (req)
	);

	palette_ram palette_ram_i (
		.V_BLANK (V_BLANK),
		.EXROM2  (EXROM2),
		.wr_i    (wr),
		.req_i   (req),
		.red_o   (red_o),
		.green_o (green_o),
		.blue_o  (blue_o)
	);

endmodule

`default_nettype wire

// File: testbench/sj_video_tb.sv
/* SJ video back end testbench
   Table of CPU and pixel steps, checked against a reference model */

`timescale 1ns/1ns
`default_nettype none

`include "sj_video_consts.svh"

module sj_video_tb;

	import sj_video_pkg::*;

	localparam int K_WRITE = 0;
	localparam int K_READ  = 1;
	localparam int K_PIXEL = 2;
	localparam int K_OUT   = 3;
	localparam logic [13:0] IDLE_PIX = 14'h0001;   // All layers clear with blank set

	logic         V_BLANK;
	logic         EXROM2;
	cpu_bus_t     cpu;
	layer_pix_t   pix;
	player_in_t   players;
	logic [7:0]   dip1;
	logic [7:0]   rdata;
	logic [2:0]   red;
	logic [2:0]   green;
	logic [2:0]   blue;
	logic         bank_sel;
	logic         sound_stop;
	logic         coin_lock;

	// ====================
	// Step table and reference model
	int           row_test [$];
	int           row_kind [$];
	logic [15:0]  row_addr [$];
	logic [15:0]  row_data [$];   // Write byte, pixel fields or players and DIP
	logic [15:0]  row_exp  [$];
	int           cur_test;
	logic [8:0]   m_pal [64];
	logic         m_latch;
	logic [7:0]   m_pry;
	color_codes_t m_codes;
	logic [2:0]   m_coin;         // bank_sel, sound_stop, coin_lock
	logic [8:0]   rgb_q [$];      // Expected RGB three edges behind the drive
	int           errors;
	int           checks;
	int           test_err;
	int           tests_ok;
	int           limit;
	int           cycles = 0;

	sj_video_top sj_video_top_i (
		.V_BLANK      (V_BLANK),
		.EXROM2       (EXROM2),
		.cpu_i        (cpu),
		.pix_i        (pix),
		.players_i    (players),
		.dip1_i       (dip1),
		.rdata_o      (rdata),
		.red_o        (red),
		.green_o      (green),
		.blue_o       (blue),
		.bank_sel_o   (bank_sel),
		.sound_stop_o (sound_stop),
		.coin_lock_o  (coin_lock)
	);

	initial begin
		V_BLANK = 1'b0;
		forever #2 V_BLANK = ~V_BLANK;
	end

	always @(posedge V_BLANK) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles > limit) begin
			$display("Timeout after %0d cycles, the step table did not finish", cycles);
			$display("*** FAILED ***");
			$finish;
		end
	end

	function automatic string test_name(input int id);
		case (id)
			1: return "reset";
			2: return "coin set";
			3: return "read port";
			4: return "palette and colour codes";
			5: return "priority";
			default: return "blanking";
		endcase
	endfunction

	function automatic layer_pix_t rand_pix(input logic [3:0] mask, input logic blank);
		layer_pix_t p;
		p.obj   = mask[0] ? 4'($urandom_range(15, 1)) : 4'h0;
		p.tm1   = mask[1] ? 3'($urandom_range(7, 1)) : 3'h0;
		p.tm2   = mask[2] ? 3'($urandom_range(7, 1)) : 3'h0;
		p.tm3   = mask[3] ? 3'($urandom_range(7, 1)) : 3'h0;
		p.blank = blank;
		return p;
	endfunction

	task automatic add_row(input int kind, input logic [15:0] addr,
		input logic [15:0] data, input logic [15:0] exp_v);
		row_test.push_back(cur_test);
		row_kind.push_back(kind);
		row_addr.push_back(addr);
		row_data.push_back(data);
		row_exp.push_back(exp_v);
	endtask

	task automatic expect_coin();
		add_row(K_OUT, 16'h0000, 16'h0000, {13'h0000, m_coin});
	endtask

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		if (addr == `SJ_A_COLOR12) begin
			m_codes.md1 = data[2:0];
			m_codes.md2 = data[6:4];
		end else if (addr == `SJ_A_COLOR3) begin
			m_codes.md3 = data[2:0];
			m_codes.md0 = data[5:4];
		end else if (addr == `SJ_A_COINSET) begin
			m_coin = {data[7], data[1], data[0]};
		end else if (addr[15:8] == `SJ_PRY_PAGE) begin
			m_pry = data;
		end else if (addr[15:8] == `SJ_PAL_PAGE && addr[0]) begin
			m_latch = data[0];   // Ninth bit waits for the even write
		end else if (addr[15:8] == `SJ_PAL_PAGE) begin
			m_pal[addr[6:1]] = {m_latch, data};
		end
		add_row(K_WRITE, addr, {8'h00, data}, 16'h0000);
	endtask

	task automatic cpu_read(input logic [15:0] addr, input logic [5:0] p, input logic [7:0] dip);
		logic [7:0] exp_v;
		exp_v = 8'h00;
		if (addr == `SJ_A_IN0) begin
			exp_v = {2'b10, p[0], p[1], p[2], p[3], p[4], p[5]};   // p is left..shoot2
		end else if (addr == `SJ_A_IN1) begin
			exp_v = 8'hFF;
		end else if (addr == `SJ_A_DIPA) begin
			exp_v = ~dip;
		end
		add_row(K_READ, addr, {2'b00, p, dip}, {8'h00, exp_v});
	endtask

	// Front opaque slot wins or slot 3 when all are clear
	task automatic pixel(input layer_pix_t p);
		logic [3:0] opq;
		logic       found;
		layer_e     lay;
		logic [5:0] idx;
		logic [8:0] exp_v;
		opq   = {|p.tm3, |p.tm2, |p.tm1, |p.obj};
		found = 1'b0;
		lay   = layer_e'(m_pry[7:6]);
		for (int k = 0; k < 4; k++) begin
			if (!found && opq[m_pry[2*k +: 2]]) begin
				lay   = layer_e'(m_pry[2*k +: 2]);
				found = 1'b1;
			end
		end
		case (lay)
			LAYER_OBJ: idx = {m_codes.md0, p.obj};
			LAYER_TM1: idx = {m_codes.md1, p.tm1};
			LAYER_TM2: idx = {m_codes.md2, p.tm2};
			default:   idx = {m_codes.md3, p.tm3};
		endcase
		exp_v = p.blank ? 9'h000 : ~m_pal[idx];
		add_row(K_PIXEL, 16'h0000, {2'b00, p}, {7'h00, exp_v});
	endtask

	task automatic report_mismatch(input string name, input logic [15:0] exp_v,
		input logic [15:0] got);
		errors++;
		test_err++;
		$display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp_v, got);
	endtask

	task automatic report_test(input int id);
		if (test_err == 0) begin
			tests_ok++;
			$display("test %0d %s: ok", id, test_name(id));
		end else begin
			$display("test %0d %s: %0d errors", id, test_name(id), test_err);
		end
		test_err = 0;
	endtask

	// ====================
	// Table build
	task automatic build_table();
		logic [8:0]  ent;
		logic [15:0] a;
		logic [7:0]  pry_set [5];
		pry_set = '{8'h1B, 8'h4E, 8'hB1, 8'h27, 8'hE4};
		cur_test = 1;
		expect_coin();
		repeat (3) expect_coin();
		cur_test = 2;
		cpu_write(`SJ_A_COINSET, 8'h83);
		expect_coin();
		cpu_write(16'hD50F, 8'h00);   // Neighbour address has no effect
		expect_coin();
		cpu_write(`SJ_A_COINSET, 8'h02);
		expect_coin();
		cpu_write(16'hD40E, 8'h81);
		expect_coin();
		cpu_write(`SJ_A_COINSET, 8'h81);
		expect_coin();
		cur_test = 3;
		cpu_read(`SJ_A_IN0, 6'b101001, 8'h5A);
		cpu_read(`SJ_A_IN0, 6'($urandom), 8'($urandom));
		cpu_read(`SJ_A_IN1, 6'($urandom), 8'h00);
		cpu_read(`SJ_A_DIPA, 6'h00, 8'h3C);
		cpu_read(`SJ_A_DIPA, 6'h3F, 8'($urandom));
		cpu_read(16'hD40B, 6'h3F, 8'h00);   // Unmapped
		cpu_read(16'h0000, 6'h15, 8'hFF);
		cpu_write(`SJ_A_IN1, 8'h00);   // Read address with rd low gives zero
		cur_test = 4;
		cpu_write({`SJ_PRY_PAGE, 8'h00}, 8'hE4);   // OBJ, TM1, TM2, TM3 front to back
		for (int e = 0; e < 64; e++) begin
			ent = 9'($urandom);
			a   = {`SJ_PAL_PAGE, 1'($urandom_range(1, 0)), 6'(e), 1'b1};
			cpu_write(a, {7'($urandom), ent[8]});
			a[0] = 1'b0;
			cpu_write(a, ent[7:0]);
		end
		repeat (2) begin
			cpu_write(`SJ_A_COLOR12, 8'($urandom));
			cpu_write(`SJ_A_COLOR3, 8'($urandom));
			repeat (24) pixel(rand_pix(4'(1 << $urandom_range(3, 0)), 1'b0));
		end
		repeat (3) expect_coin();
		cur_test = 5;
		foreach (pry_set[j]) begin
			cpu_write({`SJ_PRY_PAGE, 8'($urandom)}, pry_set[j]);
			pixel(layer_pix_t'(14'h0000));   // All transparent
			repeat (12) pixel(rand_pix(4'($urandom), 1'b0));
		end
		repeat (3) expect_coin();
		cur_test = 6;
		for (int k = 0; k < 24; k++) begin
			pixel(rand_pix(4'($urandom), (k % 3) == 1));
		end
		repeat (3) expect_coin();
	endtask

	// ====================
	// Run
	initial begin
		void'($urandom(32'h2b3bd2f3));
		EXROM2   = 1'b0;
		cpu      = '0;
		pix      = layer_pix_t'(IDLE_PIX);
		players  = '0;
		dip1     = 8'h00;
		m_latch  = 1'b0;
		m_pry    = 8'h00;
		m_codes  = '0;
		m_coin   = 3'b000;
		errors   = 0;
		checks   = 0;
		test_err = 0;
		tests_ok = 0;
		limit    = 0;
		build_table();
		limit = 10 * row_kind.size() + 200;
		repeat (3) rgb_q.push_back(9'h000);   // Reset keeps RGB dark
		repeat (2) @(posedge V_BLANK);
		EXROM2 <= 1'b1;
		for (int i = 0; i < row_kind.size(); i++) begin
			@(posedge V_BLANK);
			cpu.addr  <= row_addr[i];
			cpu.wdata <= row_data[i][7:0];
			cpu.wr    <= (row_kind[i] == K_WRITE);
			cpu.rd    <= (row_kind[i] == K_READ);
			if (row_kind[i] == K_READ) begin
				players <= player_in_t'(row_data[i][13:8]);
				dip1    <= row_data[i][7:0];
			end
			if (row_kind[i] == K_PIXEL) begin
				pix <= layer_pix_t'(row_data[i][13:0]);
				rgb_q.push_back(row_exp[i][8:0]);
			end else begin
				pix <= layer_pix_t'(IDLE_PIX);
				rgb_q.push_back(9'h000);
			end
			@(negedge V_BLANK);
			checks++;
			if ({red, green, blue} !== rgb_q[0]) begin
				report_mismatch("{red_o,green_o,blue_o}", {7'h00, rgb_q[0]},
					{7'h00, red, green, blue});
			end
			void'(rgb_q.pop_front());
			checks++;
			if (row_kind[i] == K_READ) begin
				if (rdata !== row_exp[i][7:0]) begin
					report_mismatch("rdata_o", row_exp[i], {8'h00, rdata});
				end
			end else begin
				if (rdata !== 8'h00) begin
					report_mismatch("rdata_o", 16'h0000, {8'h00, rdata});
				end
			end
			if (row_kind[i] == K_OUT) begin
				checks++;
				if ({bank_sel, sound_stop, coin_lock} !== row_exp[i][2:0]) begin
					report_mismatch("{bank_sel_o,sound_stop_o,coin_lock_o}", row_exp[i],
						{13'h0000, bank_sel, sound_stop, coin_lock});
				end
			end
			if (i == row_kind.size() - 1 || row_test[i+1] != row_test[i]) begin
				report_test(row_test[i]);
			end
		end
		$display("Summary: %0d of 6 tests ok, %0d checks, %0d errors", tests_ok, checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+include
design/sj_video_pkg.sv
design/cpu_port_decode.sv
design/video_ctrl_regs.sv
design/layer_priority_mixer.sv
design/palette_ram.sv
design/sj_video_top.sv
testbench/sj_video_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the SJ video testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module sj_video_tb -o sj_video_sim

out=$(./obj_dir/sj_video_sim)
echo "$out"

if echo "$out" | grep -qF '*** PASSED ***'; then
	exit 0
fi
exit 1
